//--- common/trace_isa_pkg.sv
// Retirement trace ISA definitions
// Widths fixed by RV32, the load/store access size encoding,
// the per-byte mask type and the two readings of a record
// instruction word.

`default_nettype none

package trace_isa_pkg;

  // Register and address width
  localparam int unsigned XLEN       = 32;
  // Register index width
  localparam int unsigned REG_ADDR_W = 5;
  // Compressed instruction width
  localparam int unsigned CINSN_W    = 16;
  // Retirement counter width
  localparam int unsigned ORDER_W    = 64;

  // Access size of a load or store
  typedef enum logic [1:0] {
    MEM_WORD = 2'b00,
    MEM_HALF = 2'b01,
    MEM_BYTE = 2'b10,
    MEM_NONE = 2'b11
  } mem_size_e;

  // One enable per byte of a word
  typedef logic [XLEN/8-1:0] byte_mask_t;

  // Compressed half with its zero pad above it
  typedef struct packed {
    logic [XLEN-CINSN_W-1:0] pad;
    logic [CINSN_W-1:0]      half;
  } insn_half_t;

  // Record instruction word, full or compressed
  typedef union packed {
    logic [XLEN-1:0] full;
    insn_half_t      c;
  } insn_word_u;

endpackage

`default_nettype wire

//--- common/trace_rec_pkg.sv
// Retirement trace records
// Events seen from the decode stage and the load/store unit,
// the per-stage capture outputs and the retirement record
// presented at the top level.

`default_nettype none

package trace_rec_pkg;

  // Decode-stage event
  typedef struct packed {
    logic                                 instr_new;
    logic                                 retire;
    logic                                 is_compressed;
    logic [trace_isa_pkg::XLEN-1:0]       insn;
    logic [trace_isa_pkg::CINSN_W-1:0]    insn_c;
    logic [trace_isa_pkg::REG_ADDR_W-1:0] rs1_addr;
    logic [trace_isa_pkg::XLEN-1:0]       rs1_rdata;
    logic [trace_isa_pkg::REG_ADDR_W-1:0] rs2_addr;
    logic [trace_isa_pkg::XLEN-1:0]       rs2_rdata;
    logic [trace_isa_pkg::REG_ADDR_W-1:0] rd_addr;
    logic [trace_isa_pkg::XLEN-1:0]       rd_wdata;
    logic                                 rd_we;
    logic [trace_isa_pkg::XLEN-1:0]       pc;
  } id_evt_t;

  // Load/store event
  typedef struct packed {
    logic                           data_valid;
    logic                           we;
    trace_isa_pkg::mem_size_e       size;
    logic [trace_isa_pkg::XLEN-1:0] addr;
    logic [trace_isa_pkg::XLEN-1:0] rdata;
    logic [trace_isa_pkg::XLEN-1:0] wdata;
    logic                           load_err;
    logic                           store_err;
  } lsu_evt_t;

  // Instruction capture output
  typedef struct packed {
    trace_isa_pkg::insn_word_u            insn;
    logic [trace_isa_pkg::XLEN-1:0]       insn_uncompressed;
    logic [trace_isa_pkg::REG_ADDR_W-1:0] rs1_addr;
    logic [trace_isa_pkg::XLEN-1:0]       rs1_rdata;
    logic [trace_isa_pkg::REG_ADDR_W-1:0] rs2_addr;
    logic [trace_isa_pkg::XLEN-1:0]       rs2_rdata;
    logic [trace_isa_pkg::REG_ADDR_W-1:0] rd_addr;
    logic [trace_isa_pkg::XLEN-1:0]       rd_wdata;
    logic [trace_isa_pkg::XLEN-1:0]       pc;
  } insn_trace_t;

  // Memory capture output
  typedef struct packed {
    logic [trace_isa_pkg::XLEN-1:0] addr;
    trace_isa_pkg::byte_mask_t      rmask;
    trace_isa_pkg::byte_mask_t      wmask;
    logic [trace_isa_pkg::XLEN-1:0] rdata;
    logic [trace_isa_pkg::XLEN-1:0] wdata;
  } mem_trace_t;

  // One retirement record
  typedef struct packed {
    logic                              valid;
    logic [trace_isa_pkg::ORDER_W-1:0] order;
    logic                              trap;
    logic                              intr;
    insn_trace_t                       insn;
    mem_trace_t                        mem;
  } retire_rec_t;

endpackage

`default_nettype wire

//--- trace/trace_insn_capture.sv
// Instruction capture stage
// Keeps the open-instruction flag, holds source operands from
// instr_new and the destination write for the open instruction,
// and builds the record instruction word.

`timescale 1ns/100ps
`default_nettype none

module trace_insn_capture (
  input  logic                        clk,
  input  logic                        rst_ni,
  input  trace_rec_pkg::id_evt_t      id_evt_i,
  output logic                        insn_open_o,
  output trace_rec_pkg::insn_trace_t  insn_o
);

  // Operand and destination holding state
  typedef struct packed {
    logic [trace_isa_pkg::REG_ADDR_W-1:0] rs1_addr;
    logic [trace_isa_pkg::XLEN-1:0]       rs1_rdata;
    logic [trace_isa_pkg::REG_ADDR_W-1:0] rs2_addr;
    logic [trace_isa_pkg::XLEN-1:0]       rs2_rdata;
    logic [trace_isa_pkg::REG_ADDR_W-1:0] rd_addr;
    logic [trace_isa_pkg::XLEN-1:0]       rd_wdata;
  } opnd_hold_t;

  logic                      open_d;
  logic                      open_q;
  opnd_hold_t                hold_d;
  opnd_hold_t                hold_q;
  trace_isa_pkg::insn_word_u insn_word;

  //////////////////////////////////////////////////////////////////////
  // Open-instruction flag
  //////////////////////////////////////////////////////////////////////

  // High from instr_new through the retire cycle
  assign open_d = id_evt_i.instr_new | open_q;

  always_ff @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      open_q <= 1'b0;
    end else if (id_evt_i.retire) begin
      open_q <= 1'b0;
    end else begin
      open_q <= open_d;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Operand and destination hold
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    hold_d = hold_q;
    // Sources sampled once per instruction
    if (id_evt_i.instr_new) begin
      hold_d.rs1_addr  = id_evt_i.rs1_addr;
      hold_d.rs1_rdata = id_evt_i.rs1_rdata;
      hold_d.rs2_addr  = id_evt_i.rs2_addr;
      hold_d.rs2_rdata = id_evt_i.rs2_rdata;
    end
    // Destination follows the write port while open
    if (open_d) begin
      if (!id_evt_i.rd_we) begin
        hold_d.rd_addr  = '0;
        hold_d.rd_wdata = '0;
      end else begin
        hold_d.rd_addr  = id_evt_i.rd_addr;
        // x0 never holds a value
        if (id_evt_i.rd_addr == '0) begin
          hold_d.rd_wdata = '0;
        end else begin
          hold_d.rd_wdata = id_evt_i.rd_wdata;
        end
      end
    end
  end

  always_ff @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      hold_q <= '0;
    end else begin
      hold_q <= hold_d;
    end
  end

  // Compressed half is zero-extended into the record word
  always_comb begin
    if (id_evt_i.is_compressed) begin
      insn_word.c.pad  = '0;
      insn_word.c.half = id_evt_i.insn_c;
    end else begin
      insn_word.full = id_evt_i.insn;
    end
  end

  always_comb begin
    insn_o.insn              = insn_word;
    insn_o.insn_uncompressed = id_evt_i.insn;
    insn_o.rs1_addr          = hold_d.rs1_addr;
    insn_o.rs1_rdata         = hold_d.rs1_rdata;
    insn_o.rs2_addr          = hold_d.rs2_addr;
    insn_o.rs2_rdata         = hold_d.rs2_rdata;
    insn_o.rd_addr           = hold_d.rd_addr;
    insn_o.rd_wdata          = hold_d.rd_wdata;
    insn_o.pc                = id_evt_i.pc;
  end

  assign insn_open_o = open_d;

endmodule

`default_nettype wire

//--- trace/trace_mem_capture.sv
// Memory capture stage
// Holds the load/store access of the open instruction and
// derives the read and write byte masks from its size.

`timescale 1ns/100ps
`default_nettype none

module trace_mem_capture (
  input  logic                       clk,
  input  logic                       rst_ni,
  input  trace_rec_pkg::lsu_evt_t    lsu_evt_i,
  input  logic                       insn_open_i,
  output trace_rec_pkg::mem_trace_t  mem_o
);

  // Access fields kept per instruction
  typedef struct packed {
    logic                           we;
    trace_isa_pkg::mem_size_e       size;
    logic [trace_isa_pkg::XLEN-1:0] addr;
    logic [trace_isa_pkg::XLEN-1:0] rdata;
    logic [trace_isa_pkg::XLEN-1:0] wdata;
  } acc_hold_t;

  acc_hold_t                 hold_d;
  acc_hold_t                 hold_q;
  trace_isa_pkg::byte_mask_t mask;

  // Take the access only when it belongs to an open instruction
  always_comb begin
    if (insn_open_i && lsu_evt_i.data_valid) begin
      hold_d.we    = lsu_evt_i.we;
      hold_d.size  = lsu_evt_i.size;
      hold_d.addr  = lsu_evt_i.addr;
      hold_d.rdata = lsu_evt_i.rdata;
      hold_d.wdata = lsu_evt_i.wdata;
    end else begin
      hold_d = hold_q;
    end
  end

  always_ff @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      hold_q <= '0;
    end else begin
      hold_q <= hold_d;
    end
  end

  // Byte enables by access size
  always_comb begin
    case (hold_d.size)
      trace_isa_pkg::MEM_WORD: mask = 4'b1111;
      trace_isa_pkg::MEM_HALF: mask = 4'b0011;
      trace_isa_pkg::MEM_BYTE: mask = 4'b0001;
      default:                 mask = 4'b0000;
    endcase
  end

  always_comb begin
    mem_o.addr  = hold_d.addr;
    mem_o.rmask = mask;
    mem_o.wmask = hold_d.we ? mask : '0;
    mem_o.rdata = hold_d.rdata;
    mem_o.wdata = hold_d.wdata;
  end

endmodule

`default_nettype wire

//--- trace/trace_retire_reg.sv
// Retirement record register
// Registers the captured instruction and memory views every
// cycle, flags a valid record the cycle after retire and keeps
// the running retirement order.

`timescale 1ns/100ps
`default_nettype none

module trace_retire_reg (
  input  logic                        clk,
  input  logic                        rst_ni,
  input  logic                        retire_i,
  input  logic                        err_i,
  input  logic                        irq_ack_i,
  input  trace_rec_pkg::insn_trace_t  insn_i,
  input  trace_rec_pkg::mem_trace_t   mem_i,
  output trace_rec_pkg::retire_rec_t  rec_o
);

  trace_rec_pkg::retire_rec_t        rec_q;
  logic [trace_isa_pkg::ORDER_W-1:0] order_inc;

  // Order advances once per presented record
  assign order_inc = {{(trace_isa_pkg::ORDER_W-1){1'b0}}, rec_q.valid};

  //////////////////////////////////////////////////////////////////////
  // Record register
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      rec_q <= '0;
    end else begin
      rec_q.valid <= retire_i;
      rec_q.order <= rec_q.order + order_inc;
      // Trap and intr track their sources regardless of valid
      rec_q.trap  <= err_i;
      rec_q.intr  <= irq_ack_i;
      rec_q.insn  <= insn_i;
      rec_q.mem   <= mem_i;
    end
  end

  assign rec_o = rec_q;

endmodule

`default_nettype wire

//--- verilog/trace_top.sv
// Retirement trace port
// Watches decode and load/store events of an in-order core and
// presents one registered record per retired instruction.

`timescale 1ns/100ps
`default_nettype none

module trace_top (
  input  logic                        clk,
  input  logic                        rst_ni,
  input  trace_rec_pkg::id_evt_t      id_evt_i,
  input  trace_rec_pkg::lsu_evt_t     lsu_evt_i,
  input  logic                        irq_ack_i,
  output trace_rec_pkg::retire_rec_t  rec_o
);

  logic                       insn_open;
  logic                       lsu_err;
  trace_rec_pkg::insn_trace_t insn_trace;
  trace_rec_pkg::mem_trace_t  mem_trace;

  // Either access fault marks the record as a trap
  assign lsu_err = lsu_evt_i.load_err | lsu_evt_i.store_err;

  trace_insn_capture u_insn_capture (
    .clk         (clk),
    .rst_ni      (rst_ni),
    .id_evt_i    (id_evt_i),
    .insn_open_o (insn_open),
    .insn_o      (insn_trace)
  );

  trace_mem_capture u_mem_capture (
    .clk         (clk),
    .rst_ni      (rst_ni),
    .lsu_evt_i   (lsu_evt_i),
    .insn_open_i (insn_open),
    .mem_o       (mem_trace)
  );

  trace_retire_reg u_retire_reg (
    .clk       (clk),
    .rst_ni    (rst_ni),
    .retire_i  (id_evt_i.retire),
    .err_i     (lsu_err),
    .irq_ack_i (irq_ack_i),
    .insn_i    (insn_trace),
    .mem_i     (mem_trace),
    .rec_o     (rec_o)
  );

endmodule

`default_nettype wire

//--- tb/trace_tb.sv
// Retirement trace port testbench
// Stands in for the pipeline, drives decode and load/store events,
// predicts each retirement record and checks it against the DUT.

`timescale 1ns/100ps
`default_nettype none

module trace_tb;

  localparam int CLK_PERIOD    = 40;
  localparam int DRIVE_DELAY   = 2;
  localparam int RESET_CYCLES  = 10;
  // Issue and drain cycles summed over the tests
  localparam int TEST_CYCLES   = RESET_CYCLES + 10 + 8 + 24 + 12 + 10;
  localparam int MARGIN_CYCLES = 40;

  logic                        clk;
  logic                        rst_ni;
  trace_rec_pkg::id_evt_t      id_evt;
  trace_rec_pkg::lsu_evt_t     lsu_evt;
  logic                        irq_ack;
  trace_rec_pkg::retire_rec_t  rec;

  logic [31:0]                 lfsr_q = 32'hc9b3;
  trace_rec_pkg::retire_rec_t  exp_q[$];
  trace_rec_pkg::mem_trace_t   mem_exp;
  logic [63:0]                 order_exp;
  int err_cnt = 0;
  int err_base = 0;
  int check_cnt = 0;
  int tests_run = 0;
  int tests_passed = 0;

  trace_top dut_i (
    .clk       (clk),
    .rst_ni    (rst_ni),
    .id_evt_i  (id_evt),
    .lsu_evt_i (lsu_evt),
    .irq_ack_i (irq_ack),
    .rec_o     (rec)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  //////////////////////////////////////////////////////////////////////
  // Random values and reference model
  //////////////////////////////////////////////////////////////////////

  // Taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = lfsr_next(lfsr_q);
      r = {r[30:0], lfsr_q[0]};
    end
    return r;
  endfunction

  function automatic trace_rec_pkg::lsu_evt_t mem_evt(
      input logic valid, input logic we, input trace_isa_pkg::mem_size_e size,
      input logic load_err, input logic store_err);
    trace_rec_pkg::lsu_evt_t e;
    e.data_valid = valid;
    e.we         = we;
    e.size       = size;
    e.addr       = rand_bits(32);
    e.rdata      = rand_bits(32);
    e.wdata      = rand_bits(32);
    e.load_err   = load_err;
    e.store_err  = store_err;
    return e;
  endfunction

  function automatic trace_rec_pkg::retire_rec_t expect_record(
      input trace_rec_pkg::id_evt_t new_e, input trace_rec_pkg::id_evt_t ret_e,
      input trace_rec_pkg::lsu_evt_t lsu, input logic irq,
      input logic [63:0] order, input trace_rec_pkg::mem_trace_t prev_mem);
    trace_rec_pkg::retire_rec_t r;
    trace_isa_pkg::byte_mask_t  mask;
    r       = '0;
    r.valid = 1'b1;
    r.order = order;
    r.trap  = lsu.load_err | lsu.store_err;
    r.intr  = irq;
    if (ret_e.is_compressed) begin
      r.insn.insn.c.pad  = '0;
      r.insn.insn.c.half = ret_e.insn_c;
    end else begin
      r.insn.insn.full = ret_e.insn;
    end
    r.insn.insn_uncompressed = ret_e.insn;
    r.insn.rs1_addr          = new_e.rs1_addr;
    r.insn.rs1_rdata         = new_e.rs1_rdata;
    r.insn.rs2_addr          = new_e.rs2_addr;
    r.insn.rs2_rdata         = new_e.rs2_rdata;
    // Unwritten destination and x0 data read as zero
    if (ret_e.rd_we) begin
      r.insn.rd_addr  = ret_e.rd_addr;
      r.insn.rd_wdata = (ret_e.rd_addr == 5'd0) ? 32'd0 : ret_e.rd_wdata;
    end
    r.insn.pc = ret_e.pc;
    r.mem     = prev_mem;
    if (lsu.data_valid) begin
      case (lsu.size)
        trace_isa_pkg::MEM_WORD: mask = 4'b1111;
        trace_isa_pkg::MEM_HALF: mask = 4'b0011;
        trace_isa_pkg::MEM_BYTE: mask = 4'b0001;
        default:                 mask = 4'b0000;
      endcase
      r.mem.addr  = lsu.addr;
      r.mem.rmask = mask;
      r.mem.wmask = lsu.we ? mask : 4'b0000;
      r.mem.rdata = lsu.rdata;
      r.mem.wdata = lsu.wdata;
    end
    return r;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////////////////////////

  // Strobes drop unless the caller drives them again
  task automatic next_cycle();
    @(posedge clk);
    #(DRIVE_DELAY);
    id_evt.instr_new = 1'b0;
    id_evt.retire    = 1'b0;
    id_evt.rd_we     = 1'b0;
    lsu_evt          = '0;
    irq_ack          = 1'b0;
  endtask

  task automatic run_insn(input logic single, input logic comp, input logic rd_we,
                          input logic [4:0] rd_addr, input trace_rec_pkg::lsu_evt_t lsu,
                          input logic irq);
    trace_rec_pkg::id_evt_t     new_e;
    trace_rec_pkg::id_evt_t     ret_e;
    trace_rec_pkg::retire_rec_t r;
    new_e               = '0;
    new_e.instr_new     = 1'b1;
    new_e.is_compressed = comp;
    new_e.insn          = rand_bits(32);
    new_e.insn_c        = 16'(rand_bits(16));
    new_e.rs1_addr      = 5'(rand_bits(5));
    new_e.rs1_rdata     = rand_bits(32);
    new_e.rs2_addr      = 5'(rand_bits(5));
    new_e.rs2_rdata     = rand_bits(32);
    new_e.rd_addr       = 5'(rand_bits(5));
    new_e.rd_wdata      = rand_bits(32);
    new_e.rd_we         = 1'b1;
    new_e.pc            = {30'(rand_bits(30)), 2'b00};
    ret_e               = new_e;
    ret_e.instr_new     = single;
    ret_e.retire        = 1'b1;
    ret_e.rd_we         = rd_we;
    ret_e.rd_addr       = rd_addr;
    ret_e.rd_wdata      = rand_bits(32);
    if (!single) begin
      next_cycle();
      id_evt = new_e;
      // Register file moves on after decode
      ret_e.rs1_rdata = rand_bits(32);
      ret_e.rs2_rdata = rand_bits(32);
    end
    next_cycle();
    id_evt  = ret_e;
    lsu_evt = lsu;
    irq_ack = irq;
    r = expect_record(new_e, ret_e, lsu, irq, order_exp, mem_exp);
    exp_q.push_back(r);
    mem_exp   = r.mem;
    order_exp = order_exp + 64'd1;
  endtask

  task automatic end_test(input string name);
    int errs;
    next_cycle();
    while (exp_q.size() != 0) @(negedge clk);
    @(negedge clk);
    errs = err_cnt - err_base;
    err_base = err_cnt;
    tests_run++;
    if (errs == 0) begin
      tests_passed++;
      $display("PASS %s", name);
    end else begin
      $display("FAIL %s with %0d errors", name, errs);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Comparison
  //////////////////////////////////////////////////////////////////////

  task automatic check_field(input string name, input logic [63:0] exp,
                             input logic [63:0] act);
    check_cnt++;
    assert (act === exp) else begin
      $display("ERR %s expected %h actual %h", name, exp, act);
      err_cnt++;
    end
  endtask

  initial begin : compare_records
    trace_rec_pkg::retire_rec_t e;
    forever begin
      @(negedge clk);
      if (rst_ni && rec.valid) begin
        if (exp_q.size() == 0) begin
          $display("Record presented without a retire to match it");
          err_cnt++;
        end else begin
          e = exp_q.pop_front();
          check_field("order", e.order, rec.order);
          check_field("trap", 64'(e.trap), 64'(rec.trap));
          check_field("intr", 64'(e.intr), 64'(rec.intr));
          check_field("insn", 64'(e.insn.insn.full), 64'(rec.insn.insn.full));
          check_field("insn_uncompressed", 64'(e.insn.insn_uncompressed),
                      64'(rec.insn.insn_uncompressed));
          check_field("rs1_addr", 64'(e.insn.rs1_addr), 64'(rec.insn.rs1_addr));
          check_field("rs1_rdata", 64'(e.insn.rs1_rdata), 64'(rec.insn.rs1_rdata));
          check_field("rs2_addr", 64'(e.insn.rs2_addr), 64'(rec.insn.rs2_addr));
          check_field("rs2_rdata", 64'(e.insn.rs2_rdata), 64'(rec.insn.rs2_rdata));
          check_field("rd_addr", 64'(e.insn.rd_addr), 64'(rec.insn.rd_addr));
          check_field("rd_wdata", 64'(e.insn.rd_wdata), 64'(rec.insn.rd_wdata));
          check_field("pc", 64'(e.insn.pc), 64'(rec.insn.pc));
          check_field("mem_addr", 64'(e.mem.addr), 64'(rec.mem.addr));
          check_field("mem_rmask", 64'(e.mem.rmask), 64'(rec.mem.rmask));
          check_field("mem_wmask", 64'(e.mem.wmask), 64'(rec.mem.wmask));
          check_field("mem_rdata", 64'(e.mem.rdata), 64'(rec.mem.rdata));
          check_field("mem_wdata", 64'(e.mem.wdata), 64'(rec.mem.wdata));
        end
      end
    end
  end

  initial begin : watchdog
    #((TEST_CYCLES + MARGIN_CYCLES) * CLK_PERIOD);
    $display("Timeout: tests did not finish within %0d cycles", TEST_CYCLES + MARGIN_CYCLES);
    $display("Simulation failed");
    $finish;
  end

  //////////////////////////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////////////////////////

  initial begin : run_tests
    rst_ni    = 1'b0;
    id_evt    = '0;
    lsu_evt   = '0;
    irq_ack   = 1'b0;
    order_exp = '0;
    mem_exp   = '0;
    // Size field resets to the word encoding
    mem_exp.rmask = 4'b1111;
    repeat (RESET_CYCLES) @(posedge clk);
    #(DRIVE_DELAY);
    rst_ni = 1'b1;

    for (int i = 0; i < 4; i++) begin
      run_insn(i[1], i[0], 1'b1, {4'(rand_bits(4)), 1'b1},
               mem_evt(1'b0, 1'b0, trace_isa_pkg::MEM_NONE, 1'b0, 1'b0), 1'b0);
    end
    end_test("register instruction");

    run_insn(1'b0, 1'b0, 1'b0, {4'(rand_bits(4)), 1'b1},
             mem_evt(1'b0, 1'b0, trace_isa_pkg::MEM_NONE, 1'b0, 1'b0), 1'b0);
    run_insn(1'b0, 1'b1, 1'b1, 5'd0,
             mem_evt(1'b0, 1'b0, trace_isa_pkg::MEM_NONE, 1'b0, 1'b0), 1'b0);
    end_test("destination zeroing");

    for (int i = 0; i < 8; i++) begin
      run_insn(1'b0, 1'b0, 1'b1, 5'(rand_bits(5)),
               mem_evt(1'b1, i[2], trace_isa_pkg::mem_size_e'(i[1:0]), 1'b0, 1'b0), 1'b0);
    end
    // Access seen while no instruction is open
    next_cycle();
    lsu_evt = mem_evt(1'b1, 1'b1, trace_isa_pkg::MEM_BYTE, 1'b0, 1'b0);
    run_insn(1'b0, 1'b0, 1'b1, 5'(rand_bits(5)),
             mem_evt(1'b0, 1'b0, trace_isa_pkg::MEM_NONE, 1'b0, 1'b0), 1'b0);
    end_test("loads and stores");

    for (int i = 0; i < 8; i++) begin
      run_insn(1'b1, i[0], 1'b1, 5'(rand_bits(5)),
               mem_evt(1'b0, 1'b0, trace_isa_pkg::MEM_NONE, 1'b0, 1'b0), 1'b0);
    end
    end_test("order numbering");

    run_insn(1'b0, 1'b0, 1'b1, 5'(rand_bits(5)),
             mem_evt(1'b1, 1'b0, trace_isa_pkg::MEM_WORD, 1'b1, 1'b0), 1'b0);
    run_insn(1'b0, 1'b0, 1'b0, 5'd0,
             mem_evt(1'b1, 1'b1, trace_isa_pkg::MEM_HALF, 1'b0, 1'b1), 1'b0);
    run_insn(1'b0, 1'b1, 1'b1, 5'(rand_bits(5)),
             mem_evt(1'b0, 1'b0, trace_isa_pkg::MEM_NONE, 1'b0, 1'b0), 1'b1);
    end_test("trap and intr");

    $display("Tests run %0d, passed %0d, checks %0d, errors %0d",
             tests_run, tests_passed, check_cnt, err_cnt);
    if (err_cnt == 0 && tests_passed == tests_run) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- filelist.f
common/trace_isa_pkg.sv
common/trace_rec_pkg.sv
trace/trace_insn_capture.sv
trace/trace_mem_capture.sv
trace/trace_retire_reg.sv
verilog/trace_top.sv
tb/trace_tb.sv
